/* include/isp_settings.svh */
`ifndef ISP_SETTINGS_SVH
`define ISP_SETTINGS_SVH

// raw sample and output channel width
`define ISP_PIXEL_WIDTH 8

// raw, gain, gain plus gamma
`define ISP_MODE_NUM 3

// white balance gains, unsigned with ISP_GAIN_FRAC fraction bits
`define ISP_GAIN_WIDTH 8
`define ISP_GAIN_FRAC 6
`define ISP_GAIN_R 8'd80 // 1.25
`define ISP_GAIN_G 8'd64 // 1.0
`define ISP_GAIN_B 8'd96 // 1.5

// command bytes from the uart side, ascii '1' and '2'
`define ISP_CMD_GAMMA1 8'h31
`define ISP_CMD_GAMMA2 8'h32

`endif

/* hdl/video_pkg.sv */
`include "isp_settings.svh"

package video_pkg;

    typedef logic [`ISP_PIXEL_WIDTH-1:0] pixel_t; // one channel sample

    typedef logic [1:0] bayer_chan_t;

    localparam bayer_chan_t CHAN_R = 2'd0;
    localparam bayer_chan_t CHAN_G = 2'd1;
    localparam bayer_chan_t CHAN_B = 2'd2;

    // stream beat between stages, no handshake
    typedef struct packed {
        logic   vsync;
        logic   den;
        pixel_t data;
    } video_beat_t;

    typedef struct packed {
        video_beat_t beat;
        bayer_chan_t chan; // bayer position of this sample
    } chan_beat_t;

    // frame buffer word, r in the top byte
    typedef struct packed {
        pixel_t r;
        pixel_t g;
        pixel_t b;
        pixel_t a;
    } rgba_word_t;

endpackage

/* hdl/isp_ctrl_pkg.sv */
package isp_ctrl_pkg;

    typedef logic [1:0] disp_mode_t;
    typedef logic [1:0] gamma_type_t;

    // display modes, stepped by the button
    localparam disp_mode_t DISP_RAW   = 2'd0;
    localparam disp_mode_t DISP_GAIN  = 2'd1;
    localparam disp_mode_t DISP_GAMMA = 2'd2; // gain plus gamma

    localparam gamma_type_t GAMMA_LINEAR = 2'd1; // identity
    localparam gamma_type_t GAMMA_KNEE   = 2'd2;

    // configuration held for a whole frame
    typedef struct packed {
        disp_mode_t  disp_mode;
        gamma_type_t gamma_type;
    } isp_cfg_t;

endpackage

/* hdl/isp_mode_ctrl.sv */
`include "isp_settings.svh"

module isp_mode_ctrl (
    input  logic                   clk50m,
    input  logic                   reset_n,
    input  logic                   button,
    input  logic                   cmd_valid,
    input  logic [7:0]             cmd_byte,
    input  logic                   in_vsync,
    output isp_ctrl_pkg::isp_cfg_t frame_cfg
);

    logic [1:0]                button_sync; // two flop synchronizer
    logic                      button_last;
    logic                      button_rise;
    logic                      vsync_last;
    logic                      frame_start;
    isp_ctrl_pkg::disp_mode_t  pending_mode;
    isp_ctrl_pkg::gamma_type_t pending_gamma;

    assign button_rise = button_sync[1] & ~button_last;
    assign frame_start = in_vsync & ~vsync_last;

    always_ff @(posedge clk50m or negedge reset_n) begin
        if (!reset_n) begin
            button_sync <= 2'b00;
            button_last <= 1'b0;
            vsync_last  <= 1'b0;
        end else begin
            button_sync <= {button_sync[0], button};
            button_last <= button_sync[1];
            vsync_last  <= in_vsync;
        end
    end

    // pending settings, may change at any time
    always_ff @(posedge clk50m or negedge reset_n) begin
        if (!reset_n) begin
            pending_mode  <= isp_ctrl_pkg::DISP_RAW;
            pending_gamma <= isp_ctrl_pkg::GAMMA_KNEE;
        end else begin
            if (button_rise) begin
                if (pending_mode == isp_ctrl_pkg::disp_mode_t'(`ISP_MODE_NUM - 1))
                    pending_mode <= isp_ctrl_pkg::DISP_RAW; // wrap
                else
                    pending_mode <= pending_mode + 2'd1;
            end
            if (cmd_valid) begin
                if (cmd_byte == `ISP_CMD_GAMMA1)
                    pending_gamma <= isp_ctrl_pkg::GAMMA_LINEAR;
                else if (cmd_byte == `ISP_CMD_GAMMA2)
                    pending_gamma <= isp_ctrl_pkg::GAMMA_KNEE;
            end
        end
    end

    // only taken over at frame start so a frame never mixes modes
    always_ff @(posedge clk50m or negedge reset_n) begin
        if (!reset_n) begin
            frame_cfg.disp_mode  <= isp_ctrl_pkg::DISP_RAW;
            frame_cfg.gamma_type <= isp_ctrl_pkg::GAMMA_KNEE;
        end else if (frame_start) begin
            frame_cfg.disp_mode  <= pending_mode;
            frame_cfg.gamma_type <= pending_gamma;
        end
    end

endmodule

/* hdl/bayer_gain.sv */
`include "isp_settings.svh"

module bayer_gain (
    input  logic                   clk50m,
    input  logic                   reset_n,
    input  video_pkg::video_beat_t in_beat,
    input  isp_ctrl_pkg::isp_cfg_t frame_cfg,
    output video_pkg::chan_beat_t  gain_beat
);

    localparam int PROD_W = `ISP_PIXEL_WIDTH + `ISP_GAIN_WIDTH;

    logic                       vsync_last;
    logic                       den_last;
    logic                       row_odd;
    logic                       col_odd;
    logic                       gain_on;
    video_pkg::bayer_chan_t     chan;
    logic [`ISP_GAIN_WIDTH-1:0] gain;
    logic [PROD_W-1:0]          product;
    logic [PROD_W-1:0]          scaled;
    video_pkg::pixel_t          gained;
    logic                       vsync_q;
    logic                       den_q;
    video_pkg::pixel_t          data_q;
    video_pkg::bayer_chan_t     chan_q;

    // row and column parity of the current pixel
    always_ff @(posedge clk50m or negedge reset_n) begin
        if (!reset_n) begin
            vsync_last <= 1'b0;
            den_last   <= 1'b0;
            row_odd    <= 1'b0;
            col_odd    <= 1'b0;
        end else begin
            vsync_last <= in_beat.vsync;
            den_last   <= in_beat.den;
            if (in_beat.vsync && !vsync_last)
                row_odd <= 1'b0; // new frame starts on an R row
            else if (den_last && !in_beat.den)
                row_odd <= ~row_odd; // end of line
            col_odd <= in_beat.den ? ~col_odd : 1'b0;
        end
    end

    // rggb pattern
    always_comb begin
        if (!row_odd && !col_odd)
            chan = video_pkg::CHAN_R;
        else if (row_odd && col_odd)
            chan = video_pkg::CHAN_B;
        else
            chan = video_pkg::CHAN_G;
    end

    always_comb begin
        case (chan)
            video_pkg::CHAN_R: gain = `ISP_GAIN_R;
            video_pkg::CHAN_B: gain = `ISP_GAIN_B;
            default:           gain = `ISP_GAIN_G;
        endcase
    end

    assign product = PROD_W'(in_beat.data) * PROD_W'(gain);
    assign scaled  = product >> `ISP_GAIN_FRAC;
    assign gained  = (|scaled[PROD_W-1:`ISP_PIXEL_WIDTH]) ? '1  // saturate
                                                          : scaled[`ISP_PIXEL_WIDTH-1:0];
    assign gain_on = (frame_cfg.disp_mode == isp_ctrl_pkg::DISP_GAIN) ||
                     (frame_cfg.disp_mode == isp_ctrl_pkg::DISP_GAMMA);

    always_ff @(posedge clk50m or negedge reset_n) begin
        if (!reset_n) begin
            vsync_q <= 1'b0;
            den_q   <= 1'b0;
        end else begin
            vsync_q <= in_beat.vsync;
            den_q   <= in_beat.den;
        end
    end

    always_ff @(posedge clk50m) begin
        data_q <= gain_on ? gained : in_beat.data;
        chan_q <= chan; // tagged in raw mode too
    end

    assign gain_beat = '{beat: '{vsync: vsync_q, den: den_q, data: data_q}, chan: chan_q};

endmodule

/* hdl/gamma_curve.sv */
module gamma_curve (
    input  logic                   clk50m,
    input  logic                   reset_n,
    input  video_pkg::chan_beat_t  gain_beat,
    input  isp_ctrl_pkg::isp_cfg_t frame_cfg,
    output video_pkg::chan_beat_t  gamma_beat
);

    video_pkg::pixel_t      x;
    video_pkg::pixel_t      curve_out;
    logic                   vsync_q;
    logic                   den_q;
    video_pkg::pixel_t      data_q;
    video_pkg::bayer_chan_t chan_q;

    assign x = gain_beat.beat.data;

    // knee curve, both segments meet at 128
    always_comb begin
        curve_out = x; // identity for type 1 and outside mode 2
        if (frame_cfg.disp_mode == isp_ctrl_pkg::DISP_GAMMA &&
            frame_cfg.gamma_type == isp_ctrl_pkg::GAMMA_KNEE) begin
            if (x < video_pkg::pixel_t'(64))
                curve_out = x << 1;
            else
                curve_out = video_pkg::pixel_t'(96) + (x >> 1); // tops out at 223
        end
    end

    always_ff @(posedge clk50m or negedge reset_n) begin
        if (!reset_n) begin
            vsync_q <= 1'b0;
            den_q   <= 1'b0;
        end else begin
            vsync_q <= gain_beat.beat.vsync;
            den_q   <= gain_beat.beat.den;
        end
    end

    always_ff @(posedge clk50m) begin
        data_q <= curve_out;
        chan_q <= gain_beat.chan;
    end

    assign gamma_beat = '{beat: '{vsync: vsync_q, den: den_q, data: data_q}, chan: chan_q};

endmodule

/* hdl/rgba_packer.sv */
module rgba_packer (
    input  logic                   clk50m,
    input  logic                   reset_n,
    input  video_pkg::chan_beat_t  gamma_beat,
    input  isp_ctrl_pkg::isp_cfg_t frame_cfg,
    output logic                   out_vsync,
    output logic                   out_den,
    output video_pkg::rgba_word_t  out_word
);

    video_pkg::rgba_word_t word;

    // no demosaic so each word only carries its own channel
    always_comb begin
        word = '0; // blank outside den
        if (gamma_beat.beat.den) begin
            word.a = '1;
            if (frame_cfg.disp_mode == isp_ctrl_pkg::DISP_RAW) begin
                word.r = gamma_beat.beat.data; // grey view of the raw mosaic
                word.g = gamma_beat.beat.data;
                word.b = gamma_beat.beat.data;
            end else begin
                case (gamma_beat.chan)
                    video_pkg::CHAN_R: word.r = gamma_beat.beat.data;
                    video_pkg::CHAN_G: word.g = gamma_beat.beat.data;
                    video_pkg::CHAN_B: word.b = gamma_beat.beat.data;
                    default:           ;
                endcase
            end
        end
    end

    always_ff @(posedge clk50m or negedge reset_n) begin
        if (!reset_n) begin
            out_vsync <= 1'b0;
            out_den   <= 1'b0;
            out_word  <= '0;
        end else begin
            out_vsync <= gamma_beat.beat.vsync;
            out_den   <= gamma_beat.beat.den; // fifo write enable downstream
            out_word  <= word;
        end
    end

endmodule

/* hdl/isp_pipeline.sv */
module isp_pipeline (
    input  logic                   clk50m,
    input  logic                   reset_n,
    input  logic                   button,
    input  logic                   cmd_valid,
    input  logic [7:0]             cmd_byte,
    input  video_pkg::video_beat_t in_beat,
    output logic                   out_vsync,
    output logic                   out_den,
    output video_pkg::rgba_word_t  out_word
);

    isp_ctrl_pkg::isp_cfg_t frame_cfg; // constant over a frame
    video_pkg::chan_beat_t  gain_beat;
    video_pkg::chan_beat_t  gamma_beat;

    isp_mode_ctrl u_mode_ctrl (
        .clk50m    (clk50m),
        .reset_n   (reset_n),
        .button    (button),
        .cmd_valid (cmd_valid),
        .cmd_byte  (cmd_byte),
        .in_vsync  (in_beat.vsync),
        .frame_cfg (frame_cfg)
    );

    // stage 1, bayer position and white balance
    bayer_gain u_bayer_gain (
        .clk50m    (clk50m),
        .reset_n   (reset_n),
        .in_beat   (in_beat),
        .frame_cfg (frame_cfg),
        .gain_beat (gain_beat)
    );

    // stage 2
    gamma_curve u_gamma_curve (
        .clk50m     (clk50m),
        .reset_n    (reset_n),
        .gain_beat  (gain_beat),
        .frame_cfg  (frame_cfg),
        .gamma_beat (gamma_beat)
    );

    // stage 3, word for the frame buffer fifo
    rgba_packer u_rgba_packer (
        .clk50m     (clk50m),
        .reset_n    (reset_n),
        .gamma_beat (gamma_beat),
        .frame_cfg  (frame_cfg),
        .out_vsync  (out_vsync),
        .out_den    (out_den),
        .out_word   (out_word)
    );

endmodule

/* testbench/tb_clock.sv */
module tb_clock (
    output logic clk50m,
    output logic reset_n
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int HALF_PERIOD  = 10; // 20 ns period
    localparam int RESET_CYCLES = 8;

    initial begin
        clk50m = 1'b0;
        forever #(HALF_PERIOD) clk50m = ~clk50m;
    end

    // reset released on a rising edge
    initial begin
        reset_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk50m);
        reset_n <= 1'b1;
    end

endmodule

/* testbench/isp_tb.sv */
`include "isp_settings.svh"

module isp_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [31:0] LFSR_SEED = 32'h2614_2c3d;
    localparam int VSYNC_CYCLES  = 2;
    localparam int PORCH_CYCLES  = 4;  // idle between vsync and first line
    localparam int FRAME_LINES   = 8;
    localparam int LINE_PIXELS   = 12;
    localparam int LINE_GAP      = 4;
    localparam int FRAME_CYCLES  = VSYNC_CYCLES + PORCH_CYCLES +
                                   FRAME_LINES * (LINE_PIXELS + LINE_GAP);
    localparam int NUM_FRAMES    = 10;
    localparam int MARGIN_CYCLES = 500; // presses, commands, reset, test ends
    localparam int TIMEOUT_NS    = (NUM_FRAMES * FRAME_CYCLES + MARGIN_CYCLES) * 20;

    // one input beat and what the model needs to predict its output
    typedef struct packed {
        video_pkg::video_beat_t beat;
        video_pkg::bayer_chan_t chan;
        isp_ctrl_pkg::isp_cfg_t cfg;
    } ref_beat_t;

    logic                      clk50m;
    logic                      reset_n;
    logic                      button;
    logic                      cmd_valid;
    logic [7:0]                cmd_byte;
    video_pkg::video_beat_t    in_beat;
    logic                      out_vsync;
    logic                      out_den;
    video_pkg::rgba_word_t     out_word;
    video_pkg::bayer_chan_t    ref_chan;
    isp_ctrl_pkg::isp_cfg_t    ref_cfg;
    ref_beat_t                 ref_d1;
    ref_beat_t                 ref_d2;
    ref_beat_t                 ref_d3;
    video_pkg::rgba_word_t     exp_word;
    isp_ctrl_pkg::disp_mode_t  model_mode;  // pending values as the DUT should hold them
    isp_ctrl_pkg::gamma_type_t model_gamma;
    logic [31:0]               lfsr_state;
    int                        cycles = 0;
    int                        fail_count = 0;
    int                        fails_before = 0;
    int                        tests_passed = 0;
    int                        tests_failed = 0;

    tb_clock u_clock (
        .clk50m  (clk50m),
        .reset_n (reset_n)
    );

    isp_pipeline dut (
        .clk50m    (clk50m),
        .reset_n   (reset_n),
        .button    (button),
        .cmd_valid (cmd_valid),
        .cmd_byte  (cmd_byte),
        .in_beat   (in_beat),
        .out_vsync (out_vsync),
        .out_den   (out_den),
        .out_word  (out_word)
    );

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0]; // taps 32 22 2 1
        return {s[30:0], fb};
    endfunction

    function automatic video_pkg::pixel_t random_pixel();
        video_pkg::pixel_t p;
        p = 8'h00;
        for (int i = 0; i < 8; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            p = {p[6:0], lfsr_state[0]};
        end
        return p;
    endfunction

    // rggb: even row even column red, odd row odd column blue
    function automatic video_pkg::bayer_chan_t rggb_channel(input int row, input int col);
        if (!row[0] && !col[0])
            return video_pkg::CHAN_R;
        else if (row[0] && col[0])
            return video_pkg::CHAN_B;
        return video_pkg::CHAN_G;
    endfunction

    function automatic video_pkg::rgba_word_t expected_word(input video_pkg::video_beat_t beat,
                                                            input video_pkg::bayer_chan_t chan,
                                                            input isp_ctrl_pkg::isp_cfg_t cfg);
        video_pkg::rgba_word_t w;
        logic [15:0]           prod;
        logic [7:0]            gain;
        video_pkg::pixel_t     v;
        w = '0;
        if (!beat.den)
            return w;
        v = beat.data;
        if (cfg.disp_mode != isp_ctrl_pkg::DISP_RAW) begin
            gain = (chan == video_pkg::CHAN_R) ? `ISP_GAIN_R :
                   (chan == video_pkg::CHAN_B) ? `ISP_GAIN_B : `ISP_GAIN_G;
            prod = (16'(beat.data) * 16'(gain)) >> `ISP_GAIN_FRAC;
            v = (prod > 16'd255) ? 8'hFF : prod[7:0];
        end
        if (cfg.disp_mode == isp_ctrl_pkg::DISP_GAMMA && cfg.gamma_type == isp_ctrl_pkg::GAMMA_KNEE)
            v = (v < 8'd64) ? {v[6:0], 1'b0} : 8'd96 + {1'b0, v[7:1]};
        w.a = 8'hFF;
        if (cfg.disp_mode == isp_ctrl_pkg::DISP_RAW) begin
            w.r = v;
            w.g = v;
            w.b = v;
        end else if (chan == video_pkg::CHAN_R)
            w.r = v;
        else if (chan == video_pkg::CHAN_B)
            w.b = v;
        else
            w.g = v;
        return w;
    endfunction

    function automatic void step_mode();
        model_mode = isp_ctrl_pkg::disp_mode_t'((int'(model_mode) + 1) % `ISP_MODE_NUM);
    endfunction

    function automatic void apply_command(input logic [7:0] cmd);
        case (cmd)
            `ISP_CMD_GAMMA1: model_gamma = isp_ctrl_pkg::GAMMA_LINEAR;
            `ISP_CMD_GAMMA2: model_gamma = isp_ctrl_pkg::GAMMA_KNEE;
            default: ; // other bytes ignored
        endcase
    endfunction

    always @(posedge clk50m) begin
        cycles <= cycles + 1;
        ref_d1 <= '{beat: in_beat, chan: ref_chan, cfg: ref_cfg};
        ref_d2 <= ref_d1;
        ref_d3 <= ref_d2; // lines up with the three DUT stages
    end

    assign exp_word = expected_word(ref_d3.beat, ref_d3.chan, ref_d3.cfg);

    a_reset_idle: assert property (@(posedge clk50m)
            (!reset_n && cycles > 1) |-> (!out_den && !out_vsync && out_word == '0))
        else begin
            fail_count = fail_count + 1;
            $display("Fail reset outputs out_den %h out_vsync %h out_word %h, expected 0 0 00000000",
                     $sampled(out_den), $sampled(out_vsync), $sampled(out_word));
        end

    a_vsync: assert property (@(posedge clk50m) disable iff (!reset_n)
            out_vsync == ref_d3.beat.vsync)
        else begin
            fail_count = fail_count + 1;
            $display("Fail out_vsync expected %h got %h",
                     $sampled(ref_d3.beat.vsync), $sampled(out_vsync));
        end

    a_den: assert property (@(posedge clk50m) disable iff (!reset_n)
            out_den == ref_d3.beat.den)
        else begin
            fail_count = fail_count + 1;
            $display("Fail out_den expected %h got %h", $sampled(ref_d3.beat.den), $sampled(out_den));
        end

    a_word: assert property (@(posedge clk50m) disable iff (!reset_n) out_word == exp_word)
        else begin
            fail_count = fail_count + 1;
            $display("Fail out_word expected %h got %h", $sampled(exp_word), $sampled(out_word));
        end

    task automatic drive_controls(input int cyc, input int press_at, input int cmd_at,
                                  input logic [7:0] cmd);
        button    <= (press_at >= 0 && cyc >= press_at && cyc < press_at + 4);
        cmd_valid <= (cyc == cmd_at);
        cmd_byte  <= (cyc == cmd_at) ? cmd : 8'h00;
    endtask

    // one frame, optional press or command part way through it
    task automatic drive_frame(input bit saturate, input int press_at, input int cmd_at,
                               input logic [7:0] cmd);
        isp_ctrl_pkg::isp_cfg_t cfg;
        video_pkg::pixel_t      pix;
        logic                   den;
        int                     cyc;
        cfg.disp_mode  = model_mode; // latched by the DUT at this vsync
        cfg.gamma_type = model_gamma;
        cyc = 0;
        for (int i = 0; i < VSYNC_CYCLES + PORCH_CYCLES; i++) begin
            @(posedge clk50m);
            in_beat  <= '{vsync: (i < VSYNC_CYCLES), den: 1'b0, data: 8'h00};
            ref_chan <= video_pkg::CHAN_R;
            ref_cfg  <= cfg;
            drive_controls(cyc, press_at, cmd_at, cmd);
            cyc++;
        end
        for (int r = 0; r < FRAME_LINES; r++) begin
            for (int c = 0; c < LINE_PIXELS + LINE_GAP; c++) begin
                den = (c < LINE_PIXELS);
                pix = 8'h00;
                if (den)
                    pix = saturate ? 8'hFF : random_pixel();
                @(posedge clk50m);
                in_beat  <= '{vsync: 1'b0, den: den, data: pix};
                ref_chan <= rggb_channel(r, c);
                drive_controls(cyc, press_at, cmd_at, cmd);
                cyc++;
            end
        end
        if (press_at >= 0)
            step_mode();
        if (cmd_at >= 0)
            apply_command(cmd);
    endtask

    task automatic press_button();
        for (int i = 0; i < 8; i++) begin
            @(posedge clk50m);
            button <= (i < 4);
        end
        step_mode();
    endtask

    task automatic send_command(input logic [7:0] cmd);
        @(posedge clk50m);
        cmd_valid <= 1'b1;
        cmd_byte  <= cmd;
        @(posedge clk50m);
        cmd_valid <= 1'b0;
        cmd_byte  <= 8'h00;
        apply_command(cmd);
    endtask

    task automatic finish_test(input string name);
        int errors;
        repeat (5) @(posedge clk50m); // let the last beats drain
        errors = fail_count - fails_before;
        fails_before = fail_count;
        if (errors == 0) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d check errors", name, errors);
        end
    endtask

    initial begin
        button      = 1'b0;
        cmd_valid   = 1'b0;
        cmd_byte    = 8'h00;
        in_beat     = '0;
        ref_chan    = video_pkg::CHAN_R;
        ref_cfg     = '0;
        lfsr_state  = LFSR_SEED;
        model_mode  = isp_ctrl_pkg::DISP_RAW;
        model_gamma = isp_ctrl_pkg::GAMMA_KNEE;
        wait (reset_n === 1'b1);
        repeat (6) @(posedge clk50m);
        drive_frame(1'b0, -1, -1, 8'h00);
        finish_test("reset_latency");
        drive_frame(1'b0, -1, -1, 8'h00);
        finish_test("raw_mode");
        press_button();
        drive_frame(1'b0, -1, -1, 8'h00);
        drive_frame(1'b1, -1, -1, 8'h00); // saturates r and b
        finish_test("gain_mode");
        press_button();
        drive_frame(1'b0, -1, -1, 8'h00); // knee curve from reset
        send_command(8'h41);
        drive_frame(1'b0, -1, -1, 8'h00);
        send_command(`ISP_CMD_GAMMA1);
        drive_frame(1'b0, -1, -1, 8'h00);
        finish_test("gamma_mode");
        drive_frame(1'b0, 40, 60, `ISP_CMD_GAMMA2); // wraps to raw, knee pending
        drive_frame(1'b0, -1, -1, 8'h00);
        press_button();
        press_button();
        drive_frame(1'b0, -1, -1, 8'h00);
        finish_test("frame_latch");
        $display("tests passed %0d, tests failed %0d, check errors %0d",
                 tests_passed, tests_failed, fail_count);
        if (fail_count == 0 && tests_failed == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
        $display("Regression failed");
        $finish;
    end

endmodule

/* tb.f */
+incdir+include
hdl/video_pkg.sv
hdl/isp_ctrl_pkg.sv
hdl/isp_mode_ctrl.sv
hdl/bayer_gain.sv
hdl/gamma_curve.sv
hdl/rgba_packer.sv
hdl/isp_pipeline.sv
testbench/tb_clock.sv
testbench/isp_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the ISP testbench with Verilator and run it.
# The log is searched for the fail message to decide the result.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=isp_tb_sim

verilator --binary --assert --timescale 1ns/1ps --top-module isp_tb -f tb.f -o "$BIN"
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Regression failed" "$LOG"; then
    exit 1
fi

exit 0
